/* hdl/rs_pkg.sv */
`default_nettype none

package rs_pkg;

    localparam int RS_DEPTH = 8;
    localparam int NUM_CDB  = 3;
    localparam int TAG_W    = 8;
    localparam int DATA_W   = 32;
    localparam int OP_W     = 4;

    typedef logic [TAG_W-1:0]    preg_tag_t;
    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [OP_W-1:0]     div_op_t;    // passed straight to the divider
    typedef logic [RS_DEPTH-1:0] rs_mask_t;
    typedef logic [NUM_CDB-1:0]  cdb_sel_t;

    typedef struct packed {
        logic      ready;                     // data valid, tag no longer waited on
        preg_tag_t tag;
        word_t     data;
    } src_operand_t;

    typedef struct packed {
        logic         valid;
        preg_tag_t    rd;
        div_op_t      op;
        src_operand_t src1;
        src_operand_t src2;
    } disp_req_t;

    typedef struct packed {
        logic      valid;
        preg_tag_t tag;
        word_t     data;
    } cdb_t;

    typedef struct packed {
        logic         busy;
        preg_tag_t    rd;
        div_op_t      op;
        src_operand_t src1;
        src_operand_t src2;
    } rs_entry_t;

    typedef struct packed {
        preg_tag_t rd;
        div_op_t   op;
        word_t     dividend;
        word_t     divisor;
    } issue_pkt_t;

    // isolate lowest set bit, used for both allocation and issue pick
    function automatic rs_mask_t lowest_one(input rs_mask_t vec);
        return vec & (~vec + rs_mask_t'(1));
    endfunction

endpackage

`default_nettype wire

/* hdl/rs_tag_snoop.sv */
`default_nettype none

module rs_tag_snoop import rs_pkg::*; (
    input  rs_entry_t    [RS_DEPTH-1:0] entries,
    input  disp_req_t                   dispatch,
    input  cdb_t         [NUM_CDB-1:0]  cdb,
    output rs_mask_t                    cap1,
    output rs_mask_t                    cap2,
    output word_t        [RS_DEPTH-1:0] cap1_data,
    output word_t        [RS_DEPTH-1:0] cap2_data,
    output src_operand_t                disp_src1,
    output src_operand_t                disp_src2
);

    function automatic cdb_sel_t tag_hits(input preg_tag_t tag,
                                          input cdb_t [NUM_CDB-1:0] bus);
        cdb_sel_t hits;
        for (int b = 0; b < NUM_CDB; b++) begin
            hits[b] = bus[b].valid && (bus[b].tag == tag);
        end
        return hits;
    endfunction

    function automatic word_t hit_data(input cdb_sel_t hits,
                                       input cdb_t [NUM_CDB-1:0] bus);
        word_t data;
        data = '0;
        for (int b = NUM_CDB - 1; b >= 0; b--) begin
            if (hits[b]) data = bus[b].data;  // lower bus overrides
        end
        return data;
    endfunction

    function automatic src_operand_t wake(input src_operand_t src,
                                          input cdb_t [NUM_CDB-1:0] bus);
        src_operand_t res;
        cdb_sel_t     hits;
        res  = src;
        hits = tag_hits(src.tag, bus);
        if (!src.ready && (|hits)) begin
            res.ready = 1'b1;
            res.data  = hit_data(hits, bus);
        end
        return res;
    endfunction

    // operands broadcast in their own dispatch cycle
    assign disp_src1 = wake(dispatch.src1, cdb);
    assign disp_src2 = wake(dispatch.src2, cdb);

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin : per_entry
            cdb_sel_t hits1;
            cdb_sel_t hits2;
            hits1        = tag_hits(entries[i].src1.tag, cdb);
            hits2        = tag_hits(entries[i].src2.tag, cdb);
            cap1[i]      = entries[i].busy && !entries[i].src1.ready && (|hits1);
            cap2[i]      = entries[i].busy && !entries[i].src2.ready && (|hits2);
            cap1_data[i] = hit_data(hits1, cdb);
            cap2_data[i] = hit_data(hits2, cdb);
        end
    end

endmodule

`default_nettype wire

/* hdl/rs_issue_select.sv */
`default_nettype none

module rs_issue_select import rs_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  rs_entry_t   [RS_DEPTH-1:0] entries,
    input  logic                       issue_ready,
    output rs_mask_t                   grant,
    output logic                       issue_valid,
    output issue_pkt_t                 issue
);

    rs_mask_t  ready_vec;
    rs_mask_t  pick;
    rs_entry_t sel;
    logic      load;

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ready_vec[i] = entries[i].busy && entries[i].src1.ready && entries[i].src2.ready;
        end
    end

    assign pick = lowest_one(ready_vec);

    // one-hot mux of the chosen entry
    always_comb begin
        sel = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (pick[i]) begin
                sel = entries[i];
            end
        end
    end

    // register empty or draining this cycle
    assign load  = (|ready_vec) && (!issue_valid || issue_ready);
    assign grant = load ? pick : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else if (load) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    // held while stalled by the divider
    always_ff @(posedge clk) begin
        if (load) begin
            issue <= '{rd:       sel.rd,
                       op:       sel.op,
                       dividend: sel.src1.data,
                       divisor:  sel.src2.data};
        end
    end

endmodule

`default_nettype wire

/* hdl/rs_entry_table.sv */
`default_nettype none

module rs_entry_table import rs_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  disp_req_t                    dispatch,
    input  src_operand_t                 disp_src1,
    input  src_operand_t                 disp_src2,
    input  rs_mask_t                     cap1,
    input  rs_mask_t                     cap2,
    input  word_t        [RS_DEPTH-1:0]  cap1_data,
    input  word_t        [RS_DEPTH-1:0]  cap2_data,
    input  rs_mask_t                     grant,
    output rs_entry_t    [RS_DEPTH-1:0]  entries,
    output logic                         dispatch_ready
);

    rs_entry_t [RS_DEPTH-1:0] entries_d;
    rs_mask_t                 free_vec;
    rs_mask_t                 alloc;
    logic                     accept;

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            free_vec[i] = !entries[i].busy;
        end
    end

    assign alloc          = lowest_one(free_vec);  // lowest free slot
    assign dispatch_ready = |free_vec;
    assign accept         = dispatch.valid && dispatch_ready;

    // next state: wakeups, then free on grant, then new dispatch
    always_comb begin
        entries_d = entries;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cap1[i]) begin
                entries_d[i].src1.ready = 1'b1;
                entries_d[i].src1.data  = cap1_data[i];
            end
            if (cap2[i]) begin
                entries_d[i].src2.ready = 1'b1;
                entries_d[i].src2.data  = cap2_data[i];
            end
            if (grant[i]) begin
                entries_d[i].busy = 1'b0;  // slot reusable next edge
            end
            // alloc only ever points at a free slot, so no clash with grant
            if (accept && alloc[i]) begin
                entries_d[i].busy = 1'b1;
                entries_d[i].rd   = dispatch.rd;
                entries_d[i].op   = dispatch.op;
                entries_d[i].src1 = disp_src1;
                entries_d[i].src2 = disp_src2;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            entries <= '0;
        end else begin
            entries <= entries_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/div_rs_top.sv */
`default_nettype none

module div_rs_top import rs_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  disp_req_t                  dispatch,
    input  cdb_t        [NUM_CDB-1:0]  cdb,
    input  logic                       issue_ready,
    output logic                       dispatch_ready,
    output logic                       issue_valid,
    output issue_pkt_t                 issue
);

    rs_entry_t    [RS_DEPTH-1:0] entries;
    rs_mask_t                    cap1;
    rs_mask_t                    cap2;
    word_t        [RS_DEPTH-1:0] cap1_data;
    word_t        [RS_DEPTH-1:0] cap2_data;
    src_operand_t                disp_src1;
    src_operand_t                disp_src2;
    rs_mask_t                    grant;

    rs_entry_table u_table (
        .clk            (clk),
        .reset          (reset),
        .dispatch       (dispatch),
        .disp_src1      (disp_src1),
        .disp_src2      (disp_src2),
        .cap1           (cap1),
        .cap2           (cap2),
        .cap1_data      (cap1_data),
        .cap2_data      (cap2_data),
        .grant          (grant),
        .entries        (entries),
        .dispatch_ready (dispatch_ready)
    );

    rs_tag_snoop u_snoop (
        .entries   (entries),
        .dispatch  (dispatch),
        .cdb       (cdb),
        .cap1      (cap1),
        .cap2      (cap2),
        .cap1_data (cap1_data),
        .cap2_data (cap2_data),
        .disp_src1 (disp_src1),
        .disp_src2 (disp_src2)
    );

    rs_issue_select u_select (
        .clk         (clk),
        .reset       (reset),
        .entries     (entries),
        .issue_ready (issue_ready),
        .grant       (grant),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

endmodule

`default_nettype wire

/* verif/div_rs_tb.sv */
`default_nettype none

module div_rs_tb import rs_pkg::*; ();

    localparam int CHUNKS     = 15;
    localparam int CHUNK_OPS  = 20;
    localparam int MAX_CYCLES = 2000;  // about 310 dispatches plus drains
    localparam int DRIVE_DLY  = 10;

    typedef struct packed {
        preg_tag_t    rd;
        div_op_t      op;
        src_operand_t s1;                  // ready means resolved
        src_operand_t s2;
    } expect_t;

    logic                      clk;
    logic                      reset;
    disp_req_t                 dispatch;
    cdb_t        [NUM_CDB-1:0] cdb;
    logic                      issue_ready;
    logic                      dispatch_ready;
    logic                      issue_valid;
    issue_pkt_t                issue;

    logic [31:0] seed;
    int          cycle_count;
    int          tag_count;
    int          rd_count;
    expect_t     pending_q[$];             // one scoreboard record per rd in flight
    preg_tag_t   owed_q[$];                // accepted tags not yet broadcast
    logic        s_fire;
    logic        s_dispatch_ready;
    logic        s_issue_valid;
    issue_pkt_t  s_issue;
    logic        prev_stall;
    issue_pkt_t  prev_issue;

    div_rs_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .issue_ready    (issue_ready),
        .dispatch_ready (dispatch_ready),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic chance(input int pct);
        return ((next_random() >> 16) % 32'd100) < pct;  // upper bits only
    endfunction

    function automatic preg_tag_t fresh_tag();
        tag_count++;
        return preg_tag_t'(tag_count);
    endfunction

    function automatic src_operand_t make_src(input logic pending);
        src_operand_t src;
        src.ready = !pending;
        src.tag   = pending ? fresh_tag() : preg_tag_t'(next_random() >> 24);
        src.data  = next_random();
        return src;
    endfunction

    function automatic int find_rd(input preg_tag_t rd);
        foreach (pending_q[k]) begin
            if (pending_q[k].rd == rd) return k;
        end
        return -1;
    endfunction

    task automatic flag_error(input string msg);
        $display("FAIL at time %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    // sample at the falling edge and move on to the next drive point
    task automatic advance_cycle();
        @(negedge clk);
        s_fire           = dispatch.valid && dispatch_ready;
        s_dispatch_ready = dispatch_ready;
        s_issue_valid    = issue_valid;
        s_issue          = issue;
        if (s_fire) begin
            if (!dispatch.src1.ready) owed_q.push_back(dispatch.src1.tag);
            if (!dispatch.src2.ready) owed_q.push_back(dispatch.src2.tag);
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic present_dispatch(input preg_tag_t rd, input logic pend1, input logic pend2);
        dispatch.valid = 1'b1;
        dispatch.rd    = rd;
        dispatch.op    = div_op_t'(next_random() >> 28);
        dispatch.src1  = make_src(pend1);
        dispatch.src2  = make_src(pend2);
    endtask

    task automatic drive_random_cdb();
        cdb = '0;
        if (owed_q.size() > 0 && chance(40)) begin
            cdb[0] = '{valid: 1'b1, tag: owed_q.pop_front(), data: next_random()};
        end
        if (cdb[0].valid && chance(25)) begin
            cdb[1] = '{valid: 1'b1, tag: cdb[0].tag, data: next_random()};  // bus 0 wins
        end else if (owed_q.size() > 0 && chance(40)) begin
            cdb[1] = '{valid: 1'b1, tag: owed_q.pop_front(), data: next_random()};
        end
        if (dispatch.valid && !dispatch.src1.ready && chance(30)) begin
            cdb[2] = '{valid: 1'b1, tag: dispatch.src1.tag, data: next_random()};
        end else if (dispatch.valid && !dispatch.src2.ready && chance(30)) begin
            cdb[2] = '{valid: 1'b1, tag: dispatch.src2.tag, data: next_random()};
        end else if (owed_q.size() > 0 && chance(40)) begin
            cdb[2] = '{valid: 1'b1, tag: owed_q.pop_front(), data: next_random()};
        end
    endtask

    task automatic drain();
        dispatch.valid = 1'b0;
        while (pending_q.size() != 0) begin
            drive_random_cdb();
            issue_ready = chance(70);
            advance_cycle();
        end
        cdb         = '0;
        issue_ready = 1'b1;
        owed_q.delete();
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    // reference model and checks on values that are stable at the falling edge
    always @(negedge clk) begin
        int         k;
        expect_t    e;
        issue_pkt_t exp_pkt;
        if (!reset) begin
            if (prev_stall) begin
                assert (issue_valid && issue == prev_issue)
                    else flag_error("issue packet changed while issue_ready was low");
            end
            prev_stall = issue_valid && !issue_ready;
            prev_issue = issue;
            if (issue_valid) begin
                k = find_rd(issue.rd);
                assert (k >= 0) else flag_error($sformatf("issued unknown rd %0h", issue.rd));
                e = pending_q[k];
                assert (e.s1.ready && e.s2.ready)
                    else flag_error($sformatf("rd %0h issued before its broadcasts", issue.rd));
                exp_pkt = '{rd: e.rd, op: e.op, dividend: e.s1.data, divisor: e.s2.data};
                assert (issue == exp_pkt)
                    else flag_error($sformatf("issue %h, expected %h", issue, exp_pkt));
                if (issue_ready) begin
                    pending_q.delete(k);
                end
            end
            if (dispatch.valid && dispatch_ready) begin
                assert (find_rd(dispatch.rd) < 0) else flag_error("rd dispatched twice in flight");
                pending_q.push_back('{rd: dispatch.rd, op: dispatch.op,
                                      s1: dispatch.src1, s2: dispatch.src2});
            end
            for (int b = 0; b < NUM_CDB; b++) begin  // lowest bus applied first and wins
                if (cdb[b].valid) begin
                    foreach (pending_q[j]) begin
                        e = pending_q[j];
                        if (!e.s1.ready && e.s1.tag == cdb[b].tag) begin
                            e.s1.ready = 1'b1;
                            e.s1.data  = cdb[b].data;
                        end
                        if (!e.s2.ready && e.s2.tag == cdb[b].tag) begin
                            e.s2.ready = 1'b1;
                            e.s2.data  = cdb[b].data;
                        end
                        pending_q[j] = e;
                    end
                end
            end
        end
    end

    initial begin
        issue_pkt_t exp_pkt;
        int         sent;
        int         waited;
        clk         = 1'b0;
        reset       = 1'b1;
        dispatch    = '0;
        cdb         = '0;
        issue_ready = 1'b0;
        seed        = 32'h7a19_95c4;
        cycle_count = 0;
        tag_count   = 0;
        rd_count    = 0;
        prev_stall  = 1'b0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        reset       = 1'b0;
        issue_ready = 1'b1;
        advance_cycle();
        assert (!s_issue_valid && s_dispatch_ready)
            else flag_error("wrong issue_valid or dispatch_ready after reset");

        present_dispatch(8'h01, 1'b0, 1'b0);  // both operands ready
        exp_pkt = '{rd: dispatch.rd, op: dispatch.op,
                    dividend: dispatch.src1.data, divisor: dispatch.src2.data};
        advance_cycle();
        assert (s_fire) else flag_error("dispatch into empty station refused");
        dispatch.valid = 1'b0;
        advance_cycle();
        assert (!s_issue_valid) else flag_error("issue_valid one cycle early");
        advance_cycle();
        assert (s_issue_valid && s_issue == exp_pkt)
            else flag_error($sformatf("ready op issue %h, expected %h", s_issue, exp_pkt));
        drain();

        for (int i = 0; i < RS_DEPTH; i++) begin
            present_dispatch(preg_tag_t'(8'h40 + i), 1'b1, 1'b0);
            advance_cycle();
            assert (s_fire) else flag_error("dispatch refused with free entries");
        end
        present_dispatch(8'h48, 1'b1, 1'b0);
        advance_cycle();
        assert (!s_fire && !s_dispatch_ready) else flag_error("dispatch_ready high when full");
        cdb[0] = '{valid: 1'b1, tag: owed_q.pop_front(), data: next_random()};
        advance_cycle();
        cdb    = '0;
        waited = 0;
        while (!s_fire && waited < 4) begin
            advance_cycle();
            waited++;
        end
        assert (s_fire) else flag_error("dispatch_ready stayed low after an issue");
        dispatch.valid = 1'b0;
        drain();

        for (int c = 0; c < CHUNKS; c++) begin
            sent = 0;
            while (sent < CHUNK_OPS || dispatch.valid) begin
                if (!dispatch.valid && sent < CHUNK_OPS && chance(70)) begin
                    present_dispatch(preg_tag_t'(rd_count), chance(50), chance(50));
                    rd_count++;
                    sent++;
                end
                drive_random_cdb();
                issue_ready = chance(70);
                advance_cycle();
                if (s_fire) dispatch.valid = 1'b0;
            end
            drain();
        end

        repeat (3) advance_cycle();  // a stray re-issue still reaches the scoreboard
        assert (!s_issue_valid && s_dispatch_ready)
            else flag_error("station not idle after the last operation issued");
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/rs_pkg.sv
hdl/rs_tag_snoop.sv
hdl/rs_issue_select.sv
hdl/rs_entry_table.sv
hdl/div_rs_top.sv
verif/div_rs_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module div_rs_tb -o div_rs_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/div_rs_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
